/* src.f */
+incdir+verilog
verilog/exec_types_pkg.sv
verilog/regfile_pkg.sv
verilog/phys_reg_file.sv
verilog/issue_ctrl.sv
verilog/mul_timer.sv
verilog/exec_units.sv
verilog/ooo_exec_top.sv
verification/ooo_exec_chk.sv
verification/ooo_exec_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module ooo_exec_tb -Mdir obj_dir -f src.f
	./obj_dir/Vooo_exec_tb > sim.log 2>&1; status=$$?; cat sim.log; test $$status -eq 0
	! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/ooo_exec_tb.sv */
// Execution slice testbench
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_exec_tb;

    // About 60 operations at up to 6 cycles each, plus margin
    localparam int MAX_CYCLES = 60 * 6 + 40;

    logic                          clk;
    logic                          rst;
    logic                          dispatch_valid;
    logic                          dispatch_ready;
    exec_types_pkg::dispatch_req_t req;
    regfile_pkg::read_req_t        query;
    regfile_pkg::read_rsp_t        query_rsp;
    exec_types_pkg::cdb_t          cdb;

    // Register values in program order, and the expected result per reorder tag
    logic [`DATA_W-1:0]       shadow [`PREG_COUNT];
    logic [`DATA_W-1:0]       expected_by_tag [2**`ROB_W];
    logic [`PREG_W-1:0]       expected_rd_by_tag [2**`ROB_W];
    logic [`ROB_W-1:0]        rob_next;
    logic [`ROB_W-1:0]        last_rob;
    regfile_pkg::preg_entry_t ent;
    exec_types_pkg::opcode_e  rnd_op;
    logic [`PREG_W-1:0]       rnd_rd;
    logic [`PREG_W-1:0]       rnd_rs1;
    logic [`PREG_W-1:0]       rnd_rs2;
    logic [`IMM_W-1:0]        li_imm [4] = '{16'h1234, 16'hfff0, 16'h0007, 16'h8000};
    int seed;
    int errors = 0;
    int cycles = 0;

    ooo_exec_top UUT (
        .clk, .rst, .dispatch_valid, .dispatch(req), .dispatch_ready,
        .query_req(query), .query_rsp, .cdb
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [`DATA_W-1:0] ref_result(input exec_types_pkg::opcode_e op,
            input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
            input logic [`IMM_W-1:0] imm);
        case (op)
            exec_types_pkg::OP_LI:  return `DATA_W'($signed(imm));
            exec_types_pkg::OP_ADD: return a + b;
            exec_types_pkg::OP_SUB: return a - b;
            default:                return a * b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [`DATA_W-1:0] expected,
                               input logic [`DATA_W-1:0] actual);
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Query one register, with settle set until its producer has written back
    task automatic read_reg(input logic [`PREG_W-1:0] idx, input bit settle);
        query.idx = idx;
        @(negedge clk);
        while (settle && query_rsp.entry.busy) begin
            @(negedge clk);
        end
        ent = query_rsp.entry;
        @(posedge clk);
        #1;
    endtask

    task automatic check_reg(input string name, input logic [`PREG_W-1:0] idx);
        read_reg(idx, 1'b1);
        check_value(name, shadow[idx], ent.value);
    endtask

    // Renamer side predicts the result and hands the operation over
    task automatic send_op(input exec_types_pkg::opcode_e op, input logic [`PREG_W-1:0] rd,
            input logic [`PREG_W-1:0] rs1, input logic [`PREG_W-1:0] rs2,
            input logic [`IMM_W-1:0] imm);
        expected_by_tag[rob_next] = ref_result(op, shadow[rs1], shadow[rs2], imm);
        expected_rd_by_tag[rob_next] = rd;
        if (rd != '0) begin
            shadow[rd] = expected_by_tag[rob_next];
        end
        req.opcode = op;
        req.rd = rd;
        req.rs1 = rs1;
        req.rs2 = rs2;
        req.imm = imm;
        req.rob_id = rob_next;
        dispatch_valid = 1'b1;
        while (!dispatch_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
        last_rob = rob_next;
        rob_next = rob_next + 1'b1;
    endtask

    // Every broadcast result against the prediction for its tag
    always @(negedge clk) begin
        if (!rst && cdb.valid) begin
            check_value($sformatf("cdb value tag %0d", cdb.rob_id),
                        expected_by_tag[cdb.rob_id], cdb.value);
            check_value($sformatf("cdb rd tag %0d", cdb.rob_id),
                        32'(expected_rd_by_tag[cdb.rob_id]), 32'(cdb.rd));
        end
    end

    initial begin
        seed = 32'heb44;
        rst = 1'b1;
        dispatch_valid = 1'b0;
        req = '0;
        query = '0;
        rob_next = '0;
        last_rob = '0;
        for (int i = 0; i < `PREG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Load immediate, sign extension and tag
        for (int i = 1; i <= 4; i++) begin
            send_op(exec_types_pkg::OP_LI, 5'(i), 5'd0, 5'd0, li_imm[i-1]);
            check_reg($sformatf("li r%0d", i), 5'(i));
            check_value($sformatf("li tag r%0d", i), 32'(last_rob), 32'(ent.rob_id));
        end

        // Dependent chain sent back to back
        send_op(exec_types_pkg::OP_ADD, 5'd5, 5'd1, 5'd2, 16'h0);
        send_op(exec_types_pkg::OP_SUB, 5'd6, 5'd5, 5'd3, 16'h0);
        send_op(exec_types_pkg::OP_ADD, 5'd7, 5'd6, 5'd5, 16'h0);
        send_op(exec_types_pkg::OP_SUB, 5'd8, 5'd7, 5'd4, 16'h0);
        for (int i = 5; i <= 8; i++) begin
            check_reg($sformatf("chain r%0d", i), 5'(i));
        end

        // Independent ADD taken while the multiply is still in flight
        send_op(exec_types_pkg::OP_MUL, 5'd10, 5'd1, 5'd3, 16'h0);
        send_op(exec_types_pkg::OP_ADD, 5'd11, 5'd2, 5'd4, 16'h0);
        read_reg(5'd10, 1'b0);
        check_value("mul busy after add accepted", 32'd1, 32'(ent.busy));
        check_reg("ooo add r11", 5'd11);
        check_reg("ooo mul r10", 5'd10);

        // Register 0 ignores writes and reads as zero
        send_op(exec_types_pkg::OP_LI, 5'd0, 5'd0, 5'd0, 16'h1234);
        read_reg(5'd0, 1'b0);
        check_value("r0 busy", '0, 32'(ent.busy));
        send_op(exec_types_pkg::OP_ADD, 5'd0, 5'd1, 5'd2, 16'h0);
        send_op(exec_types_pkg::OP_ADD, 5'd12, 5'd0, 5'd3, 16'h0);
        check_reg("r0 as source", 5'd12);
        check_reg("r0 value", 5'd0);

        // Random mix with no source naming its own destination
        for (int n = 0; n < 50; n++) begin
            rnd_op = exec_types_pkg::opcode_e'(2'($random(seed)));
            rnd_rd = 5'(1 + $unsigned($random(seed)) % 15);
            rnd_rs1 = 5'(1 + $unsigned($random(seed)) % 15);
            rnd_rs2 = 5'(1 + $unsigned($random(seed)) % 15);
            if (rnd_rs1 == rnd_rd) begin
                rnd_rs1 = 5'(rnd_rd % 15 + 1);
            end
            if (rnd_rs2 == rnd_rd) begin
                rnd_rs2 = 5'(rnd_rd % 15 + 1);
            end
            send_op(rnd_op, rnd_rd, rnd_rs1, rnd_rs2, 16'($random(seed)));
        end
        for (int i = 0; i < 16; i++) begin
            check_reg($sformatf("random r%0d", i), 5'(i));
        end

        $display("Run complete: %0d errors, %0d assertion failures in %0d cycles",
                 errors, UUT.u_chk.failures, cycles);
        if (errors == 0 && UUT.u_chk.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/ooo_exec_chk.sv */
// Dispatch and CDB protocol checks
`timescale 1ns/1ps

module ooo_exec_chk (
    input logic                          clk,
    input logic                          rst,
    input logic                          dispatch_valid,
    input logic                          dispatch_ready,
    input exec_types_pkg::dispatch_req_t dispatch,
    input exec_types_pkg::cdb_t          cdb
);

    // Assertion failures so far
    int failures = 0;

    // A broadcast result always has a real destination
    cdb_no_r0: assert property (@(posedge clk) disable iff (rst)
        cdb.valid |-> (cdb.rd != '0))
        else begin
            $error("CDB result names register 0");
            failures++;
        end

    // Stalled request held by the dispatcher
    dispatch_hold: assert property (@(posedge clk) disable iff (rst)
        (dispatch_valid && !dispatch_ready) |=> (dispatch_valid && $stable(dispatch)))
        else begin
            $error("dispatch request changed while stalled");
            failures++;
        end

    cdb_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !cdb.valid)
        else begin
            $error("CDB valid in the first cycle after reset");
            failures++;
        end

endmodule

bind ooo_exec_top ooo_exec_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch       (dispatch),
    .cdb            (cdb)
);

/* verilog/ooo_exec_top.sv */
// Out-of-order execution slice top
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_exec_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispatch_valid,
    input  exec_types_pkg::dispatch_req_t dispatch,
    output logic                          dispatch_ready,
    input  regfile_pkg::read_req_t        query_req,
    output regfile_pkg::read_rsp_t        query_rsp,
    output exec_types_pkg::cdb_t          cdb
);

    regfile_pkg::read_req_t    src_req [2];
    regfile_pkg::read_rsp_t    src_rsp [2];
    exec_types_pkg::issue_op_t issue_op;

    logic                  alu_issue;
    logic                  mul_issue;
    logic                  mul_busy;
    logic                  mul_done;
    logic [`MUL_CNT_W-1:0] mul_remaining;

    issue_ctrl u_issue_ctrl (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .src_req        (src_req),
        .src_rsp        (src_rsp),
        .mul_busy       (mul_busy),
        .mul_remaining  (mul_remaining),
        .alu_issue      (alu_issue),
        .mul_issue      (mul_issue),
        .issue_op       (issue_op)
    );

    mul_timer u_mul_timer (
        .clk       (clk),
        .rst       (rst),
        .start     (mul_issue),
        .busy      (mul_busy),
        .remaining (mul_remaining),
        .done      (mul_done)
    );

    exec_units u_exec_units (
        .clk       (clk),
        .rst       (rst),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue),
        .issue_op  (issue_op),
        .mul_done  (mul_done),
        .cdb       (cdb)
    );

    phys_reg_file u_phys_reg_file (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .src_req        (src_req),
        .src_rsp        (src_rsp),
        .query_req      (query_req),
        .query_rsp      (query_rsp)
    );

endmodule

/* verilog/exec_units.sv */
// ALU, multiplier and CDB driver
`timescale 1ns/1ps
`include "ooo_defines.svh"

module exec_units (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alu_issue,
    input  logic                      mul_issue,
    input  exec_types_pkg::issue_op_t issue_op,
    input  logic                      mul_done,
    output exec_types_pkg::cdb_t      cdb
);

    logic [`DATA_W-1:0] imm_ext;
    logic [`DATA_W-1:0] alu_next;

    // ALU result register
    logic               alu_valid;
    logic [`PREG_W-1:0] alu_rd;
    logic [`ROB_W-1:0]  alu_rob;
    logic [`DATA_W-1:0] alu_value;

    // Multiplier hold
    logic [`DATA_W-1:0] mul_a;
    logic [`DATA_W-1:0] mul_b;
    logic [`PREG_W-1:0] mul_rd;
    logic [`ROB_W-1:0]  mul_rob;
    logic [`DATA_W-1:0] mul_prod;

    assign imm_ext = {{(`DATA_W - `IMM_W){issue_op.imm[`IMM_W-1]}}, issue_op.imm};

    always_comb begin
        case (issue_op.opcode)
            exec_types_pkg::OP_LI:  alu_next = imm_ext;
            exec_types_pkg::OP_ADD: alu_next = issue_op.src1 + issue_op.src2;
            exec_types_pkg::OP_SUB: alu_next = issue_op.src1 - issue_op.src2;
            default:                alu_next = '0;
        endcase
    end

    // Results for r0 are dropped here
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= alu_issue && (issue_op.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_rd    <= issue_op.rd;
            alu_rob   <= issue_op.rob_id;
            alu_value <= alu_next;
        end
        if (mul_issue) begin
            mul_a   <= issue_op.src1;
            mul_b   <= issue_op.src2;
            mul_rd  <= issue_op.rd;
            mul_rob <= issue_op.rob_id;
        end
    end

    // Low half of the product
    assign mul_prod = mul_a * mul_b;

    // Issue rules keep the two sources apart
    always_comb begin
        cdb = '0;
        if (alu_valid) begin
            cdb.valid  = 1'b1;
            cdb.rd     = alu_rd;
            cdb.rob_id = alu_rob;
            cdb.value  = alu_value;
        end else if (mul_done && (mul_rd != '0)) begin
            cdb.valid  = 1'b1;
            cdb.rd     = mul_rd;
            cdb.rob_id = mul_rob;
            cdb.value  = mul_prod;
        end
    end

endmodule

/* verilog/mul_timer.sv */
// Multiply latency timer
`timescale 1ns/1ps
`include "ooo_defines.svh"

module mul_timer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output logic                  busy,
    output logic [`MUL_CNT_W-1:0] remaining,
    output logic                  done
);

    logic [`MUL_CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= `MUL_CNT_W'(`MUL_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign busy = (cnt != '0);

    // Last count is the product's CDB cycle
    assign done = (cnt == `MUL_CNT_W'(1));

    // Cycles left before that CDB cycle
    assign remaining = busy ? (cnt - 1'b1) : '0;

endmodule

/* verilog/issue_ctrl.sv */
// Single-entry issue controller
`timescale 1ns/1ps
`include "ooo_defines.svh"

module issue_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispatch_valid,
    input  exec_types_pkg::dispatch_req_t dispatch,
    output logic                          dispatch_ready,
    output regfile_pkg::read_req_t        src_req [2],
    input  regfile_pkg::read_rsp_t        src_rsp [2],
    input  logic                          mul_busy,
    input  logic [`MUL_CNT_W-1:0]         mul_remaining,
    output logic                          alu_issue,
    output logic                          mul_issue,
    output exec_types_pkg::issue_op_t     issue_op
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_OPS,
        ISSUE
    } state_e;

    state_e                        state;
    exec_types_pkg::dispatch_req_t op_q;

    logic ops_ready;
    logic is_mul;
    logic unit_free;

    assign dispatch_ready = (state == IDLE);

    // Sources of the held operation
    always_comb begin
        src_req[0].idx = op_q.rs1;
        src_req[1].idx = op_q.rs2;
    end

    // LI takes no sources
    assign ops_ready = (op_q.opcode == exec_types_pkg::OP_LI) ||
                       (!src_rsp[0].entry.busy && !src_rsp[1].entry.busy);

    assign is_mul = (issue_op.opcode == exec_types_pkg::OP_MUL);

    // One multiply at a time; an ALU result must not land on the product's CDB cycle
    assign unit_free = is_mul ? !mul_busy
                              : (mul_remaining != `MUL_CNT_W'(1));

    assign alu_issue = (state == ISSUE) && !is_mul && unit_free;
    assign mul_issue = (state == ISSUE) && is_mul && unit_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (dispatch_valid) begin
                        state <= WAIT_OPS;
                    end
                end
                WAIT_OPS: begin
                    if (ops_ready) begin
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (unit_free) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid && dispatch_ready) begin
            op_q <= dispatch;
        end
        // Operand values are stable once captured, the sources are no longer busy
        if ((state == WAIT_OPS) && ops_ready) begin
            issue_op.opcode <= op_q.opcode;
            issue_op.src1   <= src_rsp[0].entry.value;
            issue_op.src2   <= src_rsp[1].entry.value;
            issue_op.imm    <= op_q.imm;
            issue_op.rd     <= op_q.rd;
            issue_op.rob_id <= op_q.rob_id;
        end
    end

endmodule

/* verilog/phys_reg_file.sv */
// Physical register file with CDB bypass
`timescale 1ns/1ps
`include "ooo_defines.svh"

module phys_reg_file (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dispatch_valid,
    input  logic                        dispatch_ready,
    input  exec_types_pkg::dispatch_req_t dispatch,
    input  exec_types_pkg::cdb_t        cdb,
    input  regfile_pkg::read_req_t      src_req [2],
    output regfile_pkg::read_rsp_t      src_rsp [2],
    input  regfile_pkg::read_req_t      query_req,
    output regfile_pkg::read_rsp_t      query_rsp
);

    regfile_pkg::preg_entry_t entries [`PREG_COUNT];

    logic dispatch_fire;
    logic cdb_hit;

    assign dispatch_fire = dispatch_valid && dispatch_ready && (dispatch.rd != '0);

    // Result only lands if its producer still owns the register
    assign cdb_hit = cdb.valid && (cdb.rd != '0) &&
                     (entries[cdb.rd].rob_id == cdb.rob_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PREG_COUNT; i++) begin
                entries[i] <= '0;
            end
        end else begin
            if (cdb_hit) begin
                entries[cdb.rd].value <= cdb.value;
                entries[cdb.rd].busy  <= 1'b0;
            end
            // Later assignment, so a same-cycle dispatch keeps the register busy
            if (dispatch_fire) begin
                entries[dispatch.rd].busy   <= 1'b1;
                entries[dispatch.rd].rob_id <= dispatch.rob_id;
            end
        end
    end

    // Stored entry, overridden by the matching result on the CDB this cycle
    function automatic regfile_pkg::read_rsp_t bypass_read(
        input logic [`PREG_W-1:0]       idx,
        input regfile_pkg::preg_entry_t ent,
        input exec_types_pkg::cdb_t     res
    );
        regfile_pkg::read_rsp_t rsp;
        rsp.entry = ent;
        if (res.valid && (idx != '0) && (res.rd == idx) && (res.rob_id == ent.rob_id)) begin
            rsp.entry.value = res.value;
            rsp.entry.busy  = 1'b0;
        end
        return rsp;
    endfunction

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            src_rsp[p] = bypass_read(src_req[p].idx, entries[src_req[p].idx], cdb);
        end
        query_rsp = bypass_read(query_req.idx, entries[query_req.idx], cdb);
    end

endmodule

/* verilog/regfile_pkg.sv */
// Physical register file types
`include "ooo_defines.svh"

package regfile_pkg;

    // One physical register and its pending producer
    typedef struct packed {
        logic [`DATA_W-1:0]   value;
        logic                 busy;
        logic [`ROB_W-1:0]    rob_id;
    } preg_entry_t;

    typedef struct packed {
        logic [`PREG_W-1:0]   idx;
    } read_req_t;

    typedef struct packed {
        preg_entry_t          entry;
    } read_rsp_t;

endpackage

/* verilog/exec_types_pkg.sv */
// Operation and result bus types
`include "ooo_defines.svh"

package exec_types_pkg;

    typedef enum logic [1:0] {
        OP_LI  = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2,
        OP_MUL = 2'd3
    } opcode_e;

    // Operation as sent by the dispatcher, already renamed
    typedef struct packed {
        opcode_e              opcode;
        logic [`PREG_W-1:0]   rd;
        logic [`PREG_W-1:0]   rs1;
        logic [`PREG_W-1:0]   rs2;
        logic [`IMM_W-1:0]    imm;
        logic [`ROB_W-1:0]    rob_id;
    } dispatch_req_t;

    // Operation with its operands resolved, handed to a unit
    typedef struct packed {
        opcode_e              opcode;
        logic [`DATA_W-1:0]   src1;
        logic [`DATA_W-1:0]   src2;
        logic [`IMM_W-1:0]    imm;
        logic [`PREG_W-1:0]   rd;
        logic [`ROB_W-1:0]    rob_id;
    } issue_op_t;

    // Single-lane common data bus
    typedef struct packed {
        logic                 valid;
        logic [`PREG_W-1:0]   rd;
        logic [`ROB_W-1:0]    rob_id;
        logic [`DATA_W-1:0]   value;
    } cdb_t;

endpackage

/* verilog/ooo_defines.svh */
// Execution slice sizes and widths
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Datapath
`define DATA_W      32
`define IMM_W       16

// Physical register file
`define PREG_COUNT  32
`define PREG_W      5

// Reorder tag
`define ROB_W       5

// Multiplier issue to CDB, in cycles
`define MUL_LATENCY 4
`define MUL_CNT_W   3

`endif
